// ==== verilog/ctlb_pkg.sv ====
package ctlb_pkg;

  localparam int VPN_W = 40;                 // 52-bit address less page offset
  localparam int SET_W = 6;
  localparam int ASID_W = 16;
  localparam int PPN_W = 28;
  localparam int AGE_W = 2;
  localparam int CSR_ADDR_W = 16;
  localparam int CSR_DATA_W = 64;

  localparam int NUM_SETS = 64;
  localparam int NUM_WAYS = 4;

  typedef logic [VPN_W-1:0] vpn_t;
  typedef logic [SET_W-1:0] set_idx_t;
  typedef logic [ASID_W-1:0] asid_t;
  typedef logic [AGE_W-1:0] age_t;          // 0 is newest and 3 oldest
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [CSR_DATA_W-1:0] csr_data_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic             global;               // Matches any asid
    logic             user;
    logic             exec;
  } ctlb_data_t;

  typedef struct packed {
    logic       valid;
    vpn_t       tag;                        // Full vpn including the set bits
    asid_t      asid;
    ctlb_data_t data;
    age_t       age;
  } ctlb_entry_t;

  localparam csr_addr_t CSR_PAGE = 16'h0c10; // Low 16 bits hold the asid
  localparam csr_addr_t CSR_MFLAGS = 16'h0c00;
  localparam int MFLAGS_VM = 5;              // Virtualization enable

endpackage

// ==== verilog/ctlb_ram.sv ====
module ctlb_ram (
  input  logic                  clk,
  input  logic                  rst,
  input  ctlb_pkg::set_idx_t    read_addr,
  output ctlb_pkg::ctlb_entry_t read_data,
  input  ctlb_pkg::set_idx_t    write_addr,
  input  ctlb_pkg::ctlb_entry_t write_data,
  input  logic                  write_en
);

  ctlb_pkg::ctlb_entry_t mem [ctlb_pkg::NUM_SETS];

  assign read_data = mem[read_addr];        // Asynchronous read

  always_ff @(posedge clk)
  begin
    if (write_en)
      mem[write_addr] <= write_data;
  end

endmodule

// ==== verilog/ctlb_way.sv ====
module ctlb_way #(
  parameter int WAY_NO = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  ctlb_pkg::set_idx_t   set_idx,
  input  ctlb_pkg::vpn_t       vpn,
  input  ctlb_pkg::asid_t      asid,
  output logic                 hit,
  output ctlb_pkg::ctlb_data_t data,
  output ctlb_pkg::age_t       age,
  input  ctlb_pkg::age_t       hit_age,
  input  logic                 update,
  input  logic                 fill,
  input  ctlb_pkg::ctlb_data_t fill_data,
  input  logic                 init
);

  ctlb_pkg::ctlb_entry_t rd_entry;
  ctlb_pkg::ctlb_entry_t init_entry;
  ctlb_pkg::ctlb_entry_t fill_entry;
  ctlb_pkg::ctlb_entry_t same_entry;
  ctlb_pkg::ctlb_entry_t wr_entry;
  logic                  asid_match;
  logic                  tag_match;
  logic                  victim;
  logic                  wr_en;

  assign asid_match = (rd_entry.asid == asid) || rd_entry.data.global;
  assign tag_match = (rd_entry.tag == vpn);
  assign hit = rd_entry.valid && tag_match && asid_match;

  assign data = rd_entry.data;
  assign age = rd_entry.age;

  assign victim = (rd_entry.age == ctlb_pkg::age_t'(3)); // Oldest way takes the fill

  // Sweep seeds distinct ages so each set starts with a full LRU order
  always_comb
  begin
    init_entry = '0;
    init_entry.age = ctlb_pkg::age_t'(WAY_NO);
  end

  always_comb
  begin
    fill_entry.valid = 1'b1;
    fill_entry.tag = vpn;
    fill_entry.asid = asid;
    fill_entry.data = fill_data;
    fill_entry.age = '0;
  end

  always_comb
  begin
    same_entry = rd_entry;
    if (hit)
      same_entry.age = '0;                  // Hit way becomes newest
    else if (rd_entry.age < hit_age)
      same_entry.age = ctlb_pkg::age_t'(rd_entry.age + 2'd1);
  end

  always_comb
  begin
    if (init)
      wr_entry = init_entry;
    else if (fill && victim)
      wr_entry = fill_entry;
    else
      wr_entry = same_entry;
  end

  assign wr_en = update || init;

  ctlb_ram i_ram (
    .clk        (clk),
    .rst        (rst),
    .read_addr  (set_idx),
    .read_data  (rd_entry),
    .write_addr (set_idx),
    .write_data (wr_entry),
    .write_en   (wr_en)
  );

endmodule

// ==== verilog/csr_watch.sv ====
module csr_watch #(
  parameter ctlb_pkg::csr_addr_t CSR_ADDR = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                csr_en,
  input  ctlb_pkg::csr_addr_t csr_addr,
  input  ctlb_pkg::csr_data_t csr_data,
  output ctlb_pkg::csr_data_t value
);

  logic addr_match;

  assign addr_match = (csr_addr == CSR_ADDR);

  always_ff @(posedge clk)
  begin
    if (rst)
      value <= '0;
    else if (csr_en && addr_match)
      value <= csr_data;                    // Visible from next cycle
  end

endmodule

// ==== verilog/ctlb.sv ====
module ctlb (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lookup_en,
  input  logic                 fstall,
  input  ctlb_pkg::vpn_t       vpn,
  output logic                 read_hit,
  output ctlb_pkg::ctlb_data_t read_data,
  input  logic                 fill_en,
  input  ctlb_pkg::ctlb_data_t fill_data,
  input  logic                 csr_en,
  input  ctlb_pkg::csr_addr_t  csr_addr,
  input  ctlb_pkg::csr_data_t  csr_data,
  output logic                 ready
);

  logic [ctlb_pkg::NUM_WAYS-1:0] way_hit;
  ctlb_pkg::ctlb_data_t          way_data [ctlb_pkg::NUM_WAYS];
  ctlb_pkg::age_t                way_age [ctlb_pkg::NUM_WAYS];
  ctlb_pkg::ctlb_data_t          hit_data;
  ctlb_pkg::age_t                hit_age_any;
  ctlb_pkg::age_t                hit_age;
  ctlb_pkg::set_idx_t            set_idx;
  ctlb_pkg::set_idx_t            init_count;
  logic                          init_pending;
  logic                          fill_go;
  logic                          age_go;
  logic                          update;
  ctlb_pkg::csr_data_t           page_value;
  ctlb_pkg::csr_data_t           mflags_value;
  ctlb_pkg::asid_t               asid;

  assign ready = ~init_pending;

  assign set_idx = init_pending ? init_count : vpn[ctlb_pkg::SET_W-1:0];

  // At most one way hits, so OR-ing the masked values selects it
  always_comb
  begin
    hit_data = '0;
    hit_age_any = '0;
    for (int i = 0; i < ctlb_pkg::NUM_WAYS; i++)
    begin
      if (way_hit[i])
      begin
        hit_data = hit_data | way_data[i];
        hit_age_any = hit_age_any | way_age[i];
      end
    end
  end

  assign read_hit = (|way_hit) && ready;
  assign read_data = read_hit ? hit_data : '0;
  assign hit_age = read_hit ? hit_age_any : ctlb_pkg::age_t'(3); // Miss ages every way

  assign fill_go = fill_en && !fstall && ready;
  assign age_go = lookup_en && read_hit && !fstall && !fill_en;
  assign update = fill_go || age_go;

  assign asid = mflags_value[ctlb_pkg::MFLAGS_VM] ?
                page_value[ctlb_pkg::ASID_W-1:0] : '0;

  for (genvar k = 0; k < ctlb_pkg::NUM_WAYS; k++)
  begin : g_way
    ctlb_way #(
      .WAY_NO (k)
    ) i_way (
      .clk       (clk),
      .rst       (rst),
      .set_idx   (set_idx),
      .vpn       (vpn),
      .asid      (asid),
      .hit       (way_hit[k]),
      .data      (way_data[k]),
      .age       (way_age[k]),
      .hit_age   (hit_age),
      .update    (update),
      .fill      (fill_go),
      .fill_data (fill_data),
      .init      (init_pending)
    );
  end

  csr_watch #(
    .CSR_ADDR (ctlb_pkg::CSR_PAGE)
  ) i_page_watch (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (page_value)
  );

  csr_watch #(
    .CSR_ADDR (ctlb_pkg::CSR_MFLAGS)
  ) i_mflags_watch (
    .clk      (clk),
    .rst      (rst),
    .csr_en   (csr_en),
    .csr_addr (csr_addr),
    .csr_data (csr_data),
    .value    (mflags_value)
  );

  // One set cleared per cycle after reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      init_pending <= 1'b1;
      init_count <= '0;
    end
    else if (init_pending)
    begin
      init_count <= ctlb_pkg::set_idx_t'(init_count + 6'd1);
      if (init_count == ctlb_pkg::set_idx_t'(ctlb_pkg::NUM_SETS - 1))
        init_pending <= 1'b0;               // Last set written
    end
  end

endmodule

// ==== tb/ctlb_ref_model.sv ====
module ctlb_ref_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lookup_en,
  input  logic                 fstall,
  input  ctlb_pkg::vpn_t       vpn,
  input  logic                 fill_en,
  input  ctlb_pkg::ctlb_data_t fill_data,
  input  logic                 csr_en,
  input  ctlb_pkg::csr_addr_t  csr_addr,
  input  ctlb_pkg::csr_data_t  csr_data,
  output logic                 exp_hit,
  output ctlb_pkg::ctlb_data_t exp_data,
  output logic                 exp_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETS = ctlb_pkg::NUM_SETS;
  localparam int WAYS = ctlb_pkg::NUM_WAYS;

  logic                 m_valid [SETS][WAYS];
  ctlb_pkg::vpn_t       m_tag [SETS][WAYS];
  ctlb_pkg::asid_t      m_asid [SETS][WAYS];
  ctlb_pkg::ctlb_data_t m_data [SETS][WAYS];
  ctlb_pkg::age_t       m_age [SETS][WAYS];
  ctlb_pkg::csr_data_t  page_reg;
  ctlb_pkg::csr_data_t  mflags_reg;
  ctlb_pkg::asid_t      cur_asid;
  ctlb_pkg::set_idx_t   s;
  ctlb_pkg::age_t       hit_age;
  int                   hit_way;
  int                   init_cycles;

  assign s = vpn[ctlb_pkg::SET_W-1:0];
  assign exp_ready = (init_cycles >= SETS);    // Sweep over after one cycle per set
  assign cur_asid = mflags_reg[ctlb_pkg::MFLAGS_VM] ?
                    page_reg[ctlb_pkg::ASID_W-1:0] : '0;

  always_comb
  begin
    hit_way = 0;
    hit_age = '0;
    exp_hit = 1'b0;
    exp_data = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (m_valid[s][w] && m_tag[s][w] == vpn &&
          (m_asid[s][w] == cur_asid || m_data[s][w].global) && exp_ready)
      begin
        exp_hit = 1'b1;
        exp_data = m_data[s][w];
        hit_way = w;
        hit_age = m_age[s][w];
      end
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      init_cycles <= 0;
      page_reg <= '0;
      mflags_reg <= '0;
      for (int i = 0; i < SETS; i++)
        for (int w = 0; w < WAYS; w++)
        begin
          m_valid[i][w] <= 1'b0;
          m_age[i][w] <= ctlb_pkg::age_t'(w);  // Way number seeds the LRU order
        end
    end
    else
    begin
      if (!exp_ready)
        init_cycles <= init_cycles + 1;
      if (csr_en && csr_addr == ctlb_pkg::CSR_PAGE)
        page_reg <= csr_data;
      if (csr_en && csr_addr == ctlb_pkg::CSR_MFLAGS)
        mflags_reg <= csr_data;
      if (fill_en && !fstall && exp_ready)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (m_age[s][w] == 2'd3)
          begin
            m_valid[s][w] <= 1'b1;
            m_tag[s][w] <= vpn;
            m_asid[s][w] <= cur_asid;
            m_data[s][w] <= fill_data;
            m_age[s][w] <= '0;
          end
          else
            m_age[s][w] <= ctlb_pkg::age_t'(m_age[s][w] + 2'd1);
        end
      end
      else if (lookup_en && exp_hit && !fstall && !fill_en)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (w == hit_way)
            m_age[s][w] <= '0;
          else if (m_age[s][w] < hit_age)
            m_age[s][w] <= ctlb_pkg::age_t'(m_age[s][w] + 2'd1);
        end
      end
    end
  end

endmodule

// ==== tb/tb_ctlb.sv ====
module tb_ctlb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 6000;       // Directed part plus up to 2800 random cycles
  localparam int RANDOM_OPS = 1400;

  logic                 clk;
  logic                 rst;
  logic                 lookup_en;
  logic                 fstall;
  ctlb_pkg::vpn_t       vpn;
  logic                 read_hit;
  ctlb_pkg::ctlb_data_t read_data;
  logic                 fill_en;
  ctlb_pkg::ctlb_data_t fill_data;
  logic                 csr_en;
  ctlb_pkg::csr_addr_t  csr_addr;
  ctlb_pkg::csr_data_t  csr_data;
  logic                 ready;
  logic                 exp_hit;
  ctlb_pkg::ctlb_data_t exp_data;
  logic                 exp_ready;
  int                   cycle_count = 0;

  ctlb i_dut (
    .clk       (clk),
    .rst       (rst),
    .lookup_en (lookup_en),
    .fstall    (fstall),
    .vpn       (vpn),
    .read_hit  (read_hit),
    .read_data (read_data),
    .fill_en   (fill_en),
    .fill_data (fill_data),
    .csr_en    (csr_en),
    .csr_addr  (csr_addr),
    .csr_data  (csr_data),
    .ready     (ready)
  );

  ctlb_ref_model i_model (
    .clk       (clk),
    .rst       (rst),
    .lookup_en (lookup_en),
    .fstall    (fstall),
    .vpn       (vpn),
    .fill_en   (fill_en),
    .fill_data (fill_data),
    .csr_en    (csr_en),
    .csr_addr  (csr_addr),
    .csr_data  (csr_data),
    .exp_hit   (exp_hit),
    .exp_data  (exp_data),
    .exp_ready (exp_ready)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  assert property (@(posedge clk) disable iff (rst) ready == exp_ready)
    else stop_on_error($sformatf("Mismatch at %0t: ready %0b, expected %0b",
                                 $time, $sampled(ready), $sampled(exp_ready)));

  assert property (@(posedge clk) disable iff (rst) !ready |-> !read_hit)
    else stop_on_error($sformatf("Mismatch at %0t: read_hit high before ready", $time));

  assert property (@(posedge clk) disable iff (rst)
                   lookup_en |-> (read_hit == exp_hit && read_data == exp_data))
    else stop_on_error($sformatf("Mismatch at %0t: vpn %h hit %0b data %h, expected %0b %h",
                                 $time, $sampled(vpn), $sampled(read_hit),
                                 $sampled(read_data), $sampled(exp_hit), $sampled(exp_data)));

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_error("Timeout: the run did not finish within the cycle limit");
  end

  function automatic ctlb_pkg::vpn_t vpn_of(input int hi, input int set);
    return {34'(hi), 6'(set)};
  endfunction

  function automatic ctlb_pkg::ctlb_data_t page_data(input int ppn, input logic glob);
    ctlb_pkg::ctlb_data_t d;
    d = '0;
    d.ppn = 28'(ppn);
    d.global = glob;
    d.exec = 1'b1;
    return d;
  endfunction

  task automatic drive(input logic lk, input logic fl, input logic st,
                       input ctlb_pkg::vpn_t v, input ctlb_pkg::ctlb_data_t d);
    @(posedge clk);
    lookup_en <= lk;
    fill_en <= fl;
    fstall <= st;
    vpn <= v;
    fill_data <= d;
    csr_en <= 1'b0;
  endtask

  task automatic csr_write(input ctlb_pkg::csr_addr_t a, input ctlb_pkg::csr_data_t d);
    @(posedge clk);
    lookup_en <= 1'b0;
    fill_en <= 1'b0;
    fstall <= 1'b0;
    csr_en <= 1'b1;
    csr_addr <= a;
    csr_data <= d;
  endtask

  task automatic fill(input ctlb_pkg::vpn_t v, input ctlb_pkg::ctlb_data_t d);
    drive(1'b0, 1'b1, 1'b0, v, d);
  endtask

  // Lookup outputs settle mid-cycle
  task automatic lookup_expect(input ctlb_pkg::vpn_t v, input logic st, input logic eh,
                               input ctlb_pkg::ctlb_data_t ed);
    ctlb_pkg::ctlb_data_t want;
    want = eh ? ed : '0;
    drive(1'b1, 1'b0, st, v, '0);
    @(negedge clk);
    assert (read_hit == eh && read_data == want)
      else stop_on_error($sformatf("Mismatch at %0t: vpn %h hit %0b data %h, expected %0b %h",
                                   $time, v, read_hit, read_data, eh, want));
  endtask

  task automatic count_init_cycles();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready)
    begin
      cycles++;
      @(negedge clk);
    end
    assert (cycles == ctlb_pkg::NUM_SETS)
      else stop_on_error($sformatf("Mismatch at %0t: ready rose after %0d cycles, expected %0d",
                                   $time, cycles, ctlb_pkg::NUM_SETS));
  endtask

  task automatic eviction_order(input int set, input logic touch_first);
    ctlb_pkg::vpn_t v [5];
    ctlb_pkg::ctlb_data_t d [5];
    for (int i = 0; i < 5; i++)
    begin
      v[i] = vpn_of(i + 1, set);
      d[i] = page_data(set * 16 + i, 1'b0);
    end
    for (int i = 0; i < 4; i++)
      fill(v[i], d[i]);
    if (touch_first)
      lookup_expect(v[0], 1'b0, 1'b1, d[0]);   // First page becomes newest
    fill(v[4], d[4]);
    lookup_expect(v[0], 1'b0, touch_first, d[0]);
    lookup_expect(v[1], 1'b0, !touch_first, d[1]);
    for (int i = 2; i < 5; i++)
      lookup_expect(v[i], 1'b0, 1'b1, d[i]);
  endtask

  task automatic asid_isolation();
    ctlb_pkg::vpn_t p;
    ctlb_pkg::vpn_t g;
    ctlb_pkg::vpn_t q;
    p = vpn_of(1, 20);
    g = vpn_of(2, 20);
    q = vpn_of(3, 20);
    fill(p, page_data(28'h100, 1'b0));
    fill(g, page_data(28'h200, 1'b1));
    lookup_expect(p, 1'b0, 1'b1, page_data(28'h100, 1'b0));
    csr_write(ctlb_pkg::CSR_PAGE, 64'h1234);
    csr_write(ctlb_pkg::CSR_MFLAGS, ctlb_pkg::csr_data_t'(1) << ctlb_pkg::MFLAGS_VM);
    lookup_expect(p, 1'b0, 1'b0, '0);
    lookup_expect(g, 1'b0, 1'b1, page_data(28'h200, 1'b1));
    fill(q, page_data(28'h300, 1'b0));
    lookup_expect(q, 1'b0, 1'b1, page_data(28'h300, 1'b0));
    csr_write(ctlb_pkg::CSR_MFLAGS, '0);        // Back to asid zero
    lookup_expect(p, 1'b0, 1'b1, page_data(28'h100, 1'b0));
    lookup_expect(q, 1'b0, 1'b0, '0);
    lookup_expect(g, 1'b0, 1'b1, page_data(28'h200, 1'b1));
  endtask

  task automatic stall_freeze();
    ctlb_pkg::vpn_t v [6];
    for (int i = 0; i < 6; i++)
      v[i] = vpn_of(i + 1, 30);
    for (int i = 0; i < 4; i++)
      fill(v[i], page_data(28'h400 + i, 1'b0));
    drive(1'b0, 1'b1, 1'b1, v[4], page_data(28'h404, 1'b0));
    lookup_expect(v[0], 1'b1, 1'b1, page_data(28'h400, 1'b0)); // Stalled hit keeps age
    lookup_expect(v[4], 1'b0, 1'b0, '0);
    fill(v[5], page_data(28'h405, 1'b0));
    lookup_expect(v[0], 1'b0, 1'b0, '0);
    lookup_expect(v[1], 1'b0, 1'b1, page_data(28'h401, 1'b0));
  endtask

  // Small page pool over four sets so evictions and hits are frequent
  task automatic random_mix(input int ops);
    int op;
    logic st;
    logic present;
    ctlb_pkg::vpn_t v;
    ctlb_pkg::ctlb_data_t d;
    for (int i = 0; i < ops; i++)
    begin
      op = int'($urandom % 8);
      st = (($urandom % 8) == 0);
      v = vpn_of(int'($urandom % 6), 40 + int'($urandom % 4));
      d.ppn = 28'($urandom);
      d.global = (v[ctlb_pkg::SET_W +: 3] == 3'd0); // Fixed per page
      d.user = 1'($urandom);
      d.exec = 1'($urandom);
      if (op < 3)
      begin
        drive(1'b1, 1'b0, 1'b0, v, '0);          // Probe so a present page is not refilled
        @(negedge clk);
        present = exp_hit;
        if (!present)
          drive(1'b0, 1'b1, st, v, d);
      end
      else if (op < 7)
        drive(1'b1, 1'b0, st, v, '0);
      else if (($urandom % 3) == 0)
        csr_write(ctlb_pkg::CSR_PAGE, {48'($urandom), 16'($urandom % 4)});
      else if (($urandom % 2) == 0)
        csr_write(ctlb_pkg::CSR_MFLAGS, 64'($urandom));
      else
        csr_write(16'h0c20, 64'($urandom));
    end
  endtask

  initial
  begin
    void'($urandom(28649));
    rst = 1'b1;
    lookup_en = 1'b0;
    fstall = 1'b0;
    vpn = '0;
    fill_en = 1'b0;
    fill_data = '0;
    csr_en = 1'b0;
    csr_addr = '0;
    csr_data = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    lookup_en <= 1'b1;
    count_init_cycles();
    lookup_expect(vpn_of(1, 5), 1'b0, 1'b0, '0);
    fill(vpn_of(1, 5), page_data(28'h0a1, 1'b0));
    lookup_expect(vpn_of(1, 5), 1'b0, 1'b1, page_data(28'h0a1, 1'b0));
    eviction_order(10, 1'b0);
    eviction_order(9, 1'b1);
    asid_isolation();
    stall_freeze();
    random_mix(RANDOM_OPS);
    drive(1'b0, 1'b0, 1'b0, '0, '0);
    repeat (4) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== ctlb.f ====
verilog/ctlb_pkg.sv
verilog/ctlb_ram.sv
verilog/ctlb_way.sv
verilog/csr_watch.sv
verilog/ctlb.sv
tb/ctlb_ref_model.sv
tb/tb_ctlb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ctlb
FILELIST  = ctlb.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
